/* src/gfx_defines.svh */
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// frame geometry
`define GFX_FB_W 16
`define GFX_FB_H 8

// coordinate widths
`define GFX_X_BITS 4
`define GFX_Y_BITS 3

// 4 bits frame, 4 bits y, 4 bits x
`define GFX_PIXEL_BITS 12

// per-bank word address
`define GFX_ADDR_BITS 8

// bus data width
`define GFX_DATA_BITS 16

// frame counter width
`define GFX_FRAME_BITS 4

`endif

/* src/gfx_pkg.sv */
`include "gfx_defines.svh"

package gfx_pkg;

  typedef struct packed {
    logic [`GFX_ADDR_BITS-1:0]   awaddr;
    logic                        awvalid;
    logic [`GFX_DATA_BITS-1:0]   wdata;
    logic [`GFX_DATA_BITS/8-1:0] wstrb;
    logic                        wvalid;
    logic                        bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic [`GFX_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic                      arready;
    logic [`GFX_DATA_BITS-1:0] rdata;
    logic                      rvalid;
    logic [1:0]                rresp;
  } axil_rd_rsp_t;

  // one drawn pixel, generator to writer
  typedef struct packed {
    logic [`GFX_X_BITS-1:0]     x;
    logic [`GFX_Y_BITS-1:0]     y;
    logic [`GFX_PIXEL_BITS-1:0] color;
    logic                       last;
  } draw_t;

  // one displayed pixel
  typedef struct packed {
    logic [`GFX_X_BITS-1:0]     x;
    logic [`GFX_Y_BITS-1:0]     y;
    logic [`GFX_PIXEL_BITS-1:0] color;
    logic                       last;
  } pixel_t;

endpackage

/* src/test_pattern.sv */
`include "gfx_defines.svh"

module test_pattern (
  input  logic           clk,
  input  logic           reset,
  input  logic           frame_swap,
  output gfx_pkg::draw_t draw,
  output logic           draw_valid,
  input  logic           draw_ready
);
  localparam int unsigned X_W = `GFX_X_BITS;
  localparam int unsigned Y_W = `GFX_Y_BITS;

  logic [X_W-1:0]             x;
  logic [Y_W-1:0]             y;
  logic [`GFX_FRAME_BITS-1:0] frame_num;
  logic                       done;
  logic                       at_last;

  assign at_last = (x == X_W'(`GFX_FB_W - 1)) && (y == Y_W'(`GFX_FB_H - 1));

  always_comb begin
    draw.x     = x;
    draw.y     = y;
    draw.color = {frame_num, 4'(y), 4'(x)};
    draw.last  = at_last;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x          <= '0;
      y          <= '0;
      frame_num  <= '0;
      done       <= 1'b0;
      draw_valid <= 1'b0;
    end else if (frame_swap) begin
      // start the next frame from the origin
      x          <= '0;
      y          <= '0;
      frame_num  <= frame_num + 1'b1;
      done       <= 1'b0;
      draw_valid <= 1'b1;
    end else if (draw_valid && draw_ready) begin
      if (at_last) begin
        draw_valid <= 1'b0;
        done       <= 1'b1;
      end else if (x == X_W'(`GFX_FB_W - 1)) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end else if (!done && !draw_valid) begin
      draw_valid <= 1'b1;
    end
  end

endmodule

/* src/fb_writer.sv */
`include "gfx_defines.svh"

module fb_writer (
  input  logic                  clk,
  input  logic                  reset,
  input  gfx_pkg::draw_t        draw,
  input  logic                  draw_valid,
  output logic                  draw_ready,
  output gfx_pkg::axil_wr_req_t wr_req,
  input  gfx_pkg::axil_wr_rsp_t wr_rsp,
  output logic                  draw_done
);
  localparam int unsigned ADDR_W      = `GFX_ADDR_BITS;
  localparam int unsigned DATA_W      = `GFX_DATA_BITS;
  localparam int unsigned FRAME_WORDS = `GFX_FB_W * `GFX_FB_H;

  logic [ADDR_W-1:0] frame_addr;
  logic [ADDR_W-1:0] awaddr_q;
  logic [DATA_W-1:0] wdata_q;
  logic              awvalid_q;
  logic              busy;
  logic              last_q;
  logic              aw_done;
  logic              b_done;

  assign frame_addr = ADDR_W'(draw.y) * ADDR_W'(`GFX_FB_W) + ADDR_W'(draw.x);

  assign aw_done    = awvalid_q && wr_rsp.awready && wr_rsp.wready;
  assign b_done     = wr_rsp.bvalid && wr_req.bready;
  assign draw_ready = !busy;
  assign draw_done  = b_done && last_q;

  always_comb begin
    wr_req.awaddr  = awaddr_q;
    wr_req.awvalid = awvalid_q;
    wr_req.wdata   = wdata_q;
    wr_req.wstrb   = '1;
    wr_req.wvalid  = awvalid_q;
    // response accepted once address and data are gone
    wr_req.bready  = busy && !awvalid_q;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      awvalid_q <= 1'b0;
      busy      <= 1'b0;
      last_q    <= 1'b0;
    end else if (draw_valid && draw_ready) begin
      awvalid_q <= 1'b1;
      busy      <= 1'b1;
      last_q    <= draw.last;
    end else begin
      if (aw_done) begin
        awvalid_q <= 1'b0;
      end
      if (b_done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (draw_valid && draw_ready) begin
      awaddr_q <= frame_addr;
      wdata_q  <= DATA_W'(draw.color);
    end
  end

  a_addr_in_frame: assert property (@(posedge clk) disable iff (reset)
    wr_req.awvalid |-> (wr_req.awaddr < FRAME_WORDS));

endmodule

/* src/dbuf_frame_store.sv */
`include "gfx_defines.svh"

module dbuf_frame_store (
  input  logic                  clk,
  input  logic                  reset,
  input  gfx_pkg::axil_wr_req_t wr_req,
  output gfx_pkg::axil_wr_rsp_t wr_rsp,
  input  gfx_pkg::axil_rd_req_t rd_req,
  output gfx_pkg::axil_rd_rsp_t rd_rsp,
  input  logic                  draw_done,
  input  logic                  scan_done,
  output logic                  frame_swap
);
  localparam int unsigned ADDR_W = `GFX_ADDR_BITS;
  localparam int unsigned DATA_W = `GFX_DATA_BITS;
  localparam int unsigned STRB_W = DATA_W / 8;
  localparam int unsigned DEPTH  = 1 << ADDR_W;

  logic [DATA_W-1:0] bank0 [0:DEPTH-1];
  logic [DATA_W-1:0] bank1 [0:DEPTH-1];

  // bank currently being displayed
  logic              front;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic              draw_seen;
  logic              scan_seen;
  logic              wr_accept;
  logic              rd_accept;

  assign wr_accept = wr_req.awvalid && wr_req.wvalid && !bvalid_q;
  assign rd_accept = rd_req.arvalid && !rvalid_q;

  always_comb begin
    wr_rsp.awready = wr_accept;
    wr_rsp.wready  = wr_accept;
    wr_rsp.bvalid  = bvalid_q;
    wr_rsp.bresp   = 2'b00;
    rd_rsp.arready = !rvalid_q;
    rd_rsp.rdata   = rdata_q;
    rd_rsp.rvalid  = rvalid_q;
    rd_rsp.rresp   = 2'b00;
  end

  // writes always land in the back bank
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_req.wstrb[b]) begin
          if (front) begin
            bank0[wr_req.awaddr][8*b +: 8] <= wr_req.wdata[8*b +: 8];
          end else begin
            bank1[wr_req.awaddr][8*b +: 8] <= wr_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_q <= front ? bank1[rd_req.araddr] : bank0[rd_req.araddr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      front      <= 1'b0;
      draw_seen  <= 1'b0;
      // nothing on display yet, so no scan to wait for
      scan_seen  <= 1'b1;
      frame_swap <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (wr_req.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (rd_req.rready) begin
        rvalid_q <= 1'b0;
      end

      if (draw_seen && scan_seen) begin
        frame_swap <= 1'b1;
        front      <= ~front;
        draw_seen  <= 1'b0;
        scan_seen  <= 1'b0;
      end else begin
        frame_swap <= 1'b0;
        draw_seen  <= draw_seen || draw_done;
        scan_seen  <= scan_seen || scan_done;
      end
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid);

  a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
    rd_rsp.rvalid && !rd_req.rready |=> $stable(rd_rsp.rdata));

endmodule

/* src/pixel_stream.sv */
`include "gfx_defines.svh"

module pixel_stream (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  frame_swap,
  output gfx_pkg::axil_rd_req_t rd_req,
  input  gfx_pkg::axil_rd_rsp_t rd_rsp,
  output gfx_pkg::pixel_t       pix,
  output logic                  pix_valid,
  input  logic                  pix_ready,
  output logic                  scan_done
);
  localparam int unsigned X_W    = `GFX_X_BITS;
  localparam int unsigned Y_W    = `GFX_Y_BITS;
  localparam int unsigned ADDR_W = `GFX_ADDR_BITS;
  localparam int unsigned PIX_W  = `GFX_PIXEL_BITS;

  logic [X_W-1:0]  sx;
  logic [Y_W-1:0]  sy;
  logic            arvalid_q;
  gfx_pkg::pixel_t pix_q;
  logic            pix_valid_q;
  logic            at_last;
  logic            rd_accept;
  logic            capture;
  logic            pix_accept;

  assign at_last    = (sx == X_W'(`GFX_FB_W - 1)) && (sy == Y_W'(`GFX_FB_H - 1));
  assign rd_accept  = arvalid_q && rd_rsp.arready;
  assign capture    = rd_rsp.rvalid && rd_req.rready;
  assign pix_accept = pix_valid_q && pix_ready;

  always_comb begin
    rd_req.araddr  = ADDR_W'(sy) * ADDR_W'(`GFX_FB_W) + ADDR_W'(sx);
    rd_req.arvalid = arvalid_q;
    // take read data only into an empty output register
    rd_req.rready  = !pix_valid_q;
  end

  assign pix       = pix_q;
  assign pix_valid = pix_valid_q;
  assign scan_done = pix_accept && pix_q.last;

  always_ff @(posedge clk) begin
    if (reset) begin
      sx          <= '0;
      sy          <= '0;
      arvalid_q   <= 1'b0;
      pix_valid_q <= 1'b0;
    end else if (frame_swap) begin
      sx        <= '0;
      sy        <= '0;
      arvalid_q <= 1'b1;
    end else begin
      if (rd_accept) begin
        arvalid_q <= 1'b0;
      end
      if (capture) begin
        pix_valid_q <= 1'b1;
        if (at_last) begin
          sx <= '0;
          sy <= '0;
        end else if (sx == X_W'(`GFX_FB_W - 1)) begin
          sx <= '0;
          sy <= sy + 1'b1;
        end else begin
          sx <= sx + 1'b1;
        end
      end
      if (pix_accept) begin
        pix_valid_q <= 1'b0;
        // last pixel waits for the next swap
        if (!pix_q.last) begin
          arvalid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      pix_q.x     <= sx;
      pix_q.y     <= sy;
      pix_q.color <= rd_rsp.rdata[PIX_W-1:0];
      pix_q.last  <= at_last;
    end
  end

  a_pix_hold: assert property (@(posedge clk) disable iff (reset)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix));

endmodule

/* src/gfx_demo.sv */
module gfx_demo (
  input  logic            clk,
  input  logic            reset,
  output gfx_pkg::pixel_t pix,
  output logic            pix_valid,
  input  logic            pix_ready
);
  gfx_pkg::draw_t        draw;
  logic                  draw_valid;
  logic                  draw_ready;
  gfx_pkg::axil_wr_req_t wr_req;
  gfx_pkg::axil_wr_rsp_t wr_rsp;
  gfx_pkg::axil_rd_req_t rd_req;
  gfx_pkg::axil_rd_rsp_t rd_rsp;
  logic                  frame_swap;
  logic                  draw_done;
  logic                  scan_done;

  test_pattern u_pattern (
    .clk       (clk),
    .reset     (reset),
    .frame_swap(frame_swap),
    .draw      (draw),
    .draw_valid(draw_valid),
    .draw_ready(draw_ready)
  );

  // drawn pixels become writes to the back bank
  fb_writer u_writer (
    .clk       (clk),
    .reset     (reset),
    .draw      (draw),
    .draw_valid(draw_valid),
    .draw_ready(draw_ready),
    .wr_req    (wr_req),
    .wr_rsp    (wr_rsp),
    .draw_done (draw_done)
  );

  dbuf_frame_store u_store (
    .clk       (clk),
    .reset     (reset),
    .wr_req    (wr_req),
    .wr_rsp    (wr_rsp),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .draw_done (draw_done),
    .scan_done (scan_done),
    .frame_swap(frame_swap)
  );

  // front bank scanned out in raster order
  pixel_stream u_stream (
    .clk       (clk),
    .reset     (reset),
    .frame_swap(frame_swap),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .pix       (pix),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .scan_done (scan_done)
  );

endmodule

/* tb/gfx_demo_tb.sv */
`include "gfx_defines.svh"

module gfx_demo_tb;
  localparam int unsigned FB_W          = `GFX_FB_W;
  localparam int unsigned FB_H          = `GFX_FB_H;
  localparam int unsigned X_W           = `GFX_X_BITS;
  localparam int unsigned Y_W           = `GFX_Y_BITS;
  localparam int unsigned FRAME_PIXELS  = FB_W * FB_H;
  localparam int unsigned NUM_FRAMES    = 4;
  localparam int unsigned CLK_PERIOD    = 8;
  // six frames at up to 16 cycles a pixel
  localparam int unsigned WATCHDOG_TIME = 6 * FRAME_PIXELS * 16 * CLK_PERIOD;

  logic            clk;
  logic            reset;
  gfx_pkg::pixel_t pix;
  logic            pix_valid;
  logic            pix_ready;

  logic [31:0]     lfsr;
  int unsigned     exp_x;
  int unsigned     exp_y;
  int unsigned     exp_frame;
  int unsigned     frames_seen;
  int unsigned     pixels_seen;
  int unsigned     hold_events;
  int unsigned     errors_reset;
  int unsigned     errors_first;
  int unsigned     errors_frames;
  int unsigned     errors_hold;
  int unsigned     errors_last;
  logic            held_valid;
  gfx_pkg::pixel_t held_pix;

  gfx_demo UUT (
    .clk      (clk),
    .reset    (reset),
    .pix      (pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // frame number on top, then y, then x
  function automatic logic [`GFX_PIXEL_BITS-1:0] ref_color(input int unsigned frame,
                                                          input int unsigned x,
                                                          input int unsigned y);
    return {4'(frame), 4'(y), 4'(x)};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Fail time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
  endtask

  task automatic report_test(input int num, input string name, input int unsigned errors);
    if (errors == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors);
    end
  endtask

  // two bits per cycle, ready unless both are set
  always @(posedge clk) begin
    logic b0;
    logic b1;
    #1;
    lfsr = lfsr_next(lfsr);
    b0   = lfsr[0];
    lfsr = lfsr_next(lfsr);
    b1   = lfsr[0];
    pix_ready = !(b0 && b1);
  end

  always @(negedge clk) begin
    logic [`GFX_PIXEL_BITS-1:0] exp_color;
    logic                       exp_last;
    logic                       bad;
    if (reset) begin
      held_valid = 1'b0;
      if (pix_valid !== 1'b0) begin
        report_mismatch("pix_valid", 32'(pix_valid), 32'd0);
        errors_reset++;
      end
    end else if (frames_seen < NUM_FRAMES) begin
      // stalled pixel must still be there, unchanged
      if (held_valid) begin
        hold_events++;
        if (pix_valid !== 1'b1) begin
          report_mismatch("pix_valid", 32'(pix_valid), 32'd1);
          errors_hold++;
        end else if (pix !== held_pix) begin
          report_mismatch("pix", 32'(pix), 32'(held_pix));
          errors_hold++;
        end
      end
      held_valid = pix_valid && !pix_ready;
      held_pix   = pix;
      if (pix_valid === 1'b1 && pix_ready === 1'b1) begin
        exp_color = ref_color(exp_frame, exp_x, exp_y);
        exp_last  = (exp_x == FB_W - 1) && (exp_y == FB_H - 1);
        bad       = 1'b0;
        if (pix.x !== X_W'(exp_x)) begin
          report_mismatch("pix.x", 32'(pix.x), exp_x);
          bad = 1'b1;
        end
        if (pix.y !== Y_W'(exp_y)) begin
          report_mismatch("pix.y", 32'(pix.y), exp_y);
          bad = 1'b1;
        end
        if (pix.color !== exp_color) begin
          report_mismatch("pix.color", 32'(pix.color), 32'(exp_color));
          bad = 1'b1;
        end
        if (pix.last !== exp_last) begin
          report_mismatch("pix.last", 32'(pix.last), 32'(exp_last));
          errors_last++;
        end
        if (bad) begin
          errors_frames++;
          if (exp_frame == 0) begin
            errors_first++;
          end
        end
        pixels_seen++;
        if (exp_last) begin
          if (exp_frame == 0) begin
            report_test(2, "first frame in raster order", errors_first);
          end
          if (frames_seen + 1 == NUM_FRAMES) begin
            report_test(3, "four frames in order", errors_frames);
          end
          exp_x = 0;
          exp_y = 0;
          exp_frame++;
          frames_seen++;
        end else if (exp_x == FB_W - 1) begin
          exp_x = 0;
          exp_y++;
        end else begin
          exp_x++;
        end
      end
    end
  end

  initial begin
    int unsigned total;
    reset         = 1'b1;
    pix_ready     = 1'b0;
    lfsr          = 32'h4faa_f307;
    exp_x         = 0;
    exp_y         = 0;
    exp_frame     = 0;
    frames_seen   = 0;
    pixels_seen   = 0;
    hold_events   = 0;
    errors_reset  = 0;
    errors_first  = 0;
    errors_frames = 0;
    errors_hold   = 0;
    errors_last   = 0;
    held_valid    = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    // nothing can be on display this early
    repeat (4) begin
      @(negedge clk);
      if (pix_valid !== 1'b0) begin
        report_mismatch("pix_valid", 32'(pix_valid), 32'd0);
        errors_reset++;
      end
    end
    report_test(1, "pix_valid low in and after reset", errors_reset);

    wait (frames_seen == NUM_FRAMES);
    if (hold_events == 0) begin
      $display("no stall on pix_ready was seen, hold check never ran");
      errors_hold++;
    end
    report_test(4, "pixel held under back-pressure", errors_hold);
    report_test(5, "last only on the final pixel", errors_last);

    total = errors_reset + errors_frames + errors_hold + errors_last;
    $display("summary: %0d pixels, %0d frames, %0d stalls, %0d errors",
             pixels_seen, frames_seen, hold_events, total);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: only %0d of %0d frames arrived within %0d cycles",
             frames_seen, NUM_FRAMES, WATCHDOG_TIME / CLK_PERIOD);
    $display("tests failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+src
src/gfx_pkg.sv
src/test_pattern.sv
src/fb_writer.sv
src/dbuf_frame_store.sv
src/pixel_stream.sv
src/gfx_demo.sv
tb/gfx_demo_tb.sv

/* run.sh */
#!/bin/sh
# build and run the gfx_demo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module gfx_demo_tb -o gfx_demo_sim
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

out=$(./obj_dir/gfx_demo_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
